// ==== snes_glue_pkg.sv ====
package snes_glue_pkg;

  // loader stream byte address
  typedef logic [24:0] dl_addr_t;
  // core side rom byte address
  typedef logic [23:0] rom_addr_t;
  typedef logic [23:0] mask_t;
  typedef logic [15:0] word_t;
  typedef logic [7:0]  byte_t;
  // size is 1024 << code
  typedef logic [3:0]  size_code_t;
  // mapping type from the image header
  typedef logic [7:0]  rom_type_t;
  typedef logic [5:0]  dl_index_t;
  // post download countdown
  typedef logic [2:0]  settle_cnt_t;

  typedef struct packed {
    logic      download;
    logic      wr;
    dl_addr_t  addr;
    word_t     dout;
    dl_index_t index;
  } loader_t;

  typedef struct packed {
    rom_addr_t addr;
    word_t     d;
    logic      oe_n;
    logic      we_n;
    logic      word;
  } core_rom_t;

  typedef struct packed {
    dl_addr_t addr;
    word_t    data;
    logic     rd;
    logic     wr;
    logic     word;
  } rom_req_t;

  typedef struct packed {
    logic [19:0] addr;
    byte_t       d;
    logic        ce_n;
    logic        oe_n;
    logic        we_n;
  } core_bsram_t;

  // 16 bit wide save ram, byte lanes via be_hi / be_lo
  typedef struct packed {
    logic [15:0] waddr;
    word_t       data;
    logic        wr;
    logic        rd;
    logic        be_hi;
    logic        be_lo;
  } bsram_req_t;

  // copier header in front of some images
  localparam int unsigned HEADER_BYTES = 512;
  localparam settle_cnt_t SETTLE_COUNT = 3'd6;
  // nothing loaded since reset
  localparam settle_cnt_t SETTLE_IDLE = 3'd7;
  localparam size_code_t DEFAULT_ROM_SIZE = 4'hC;
  localparam dl_index_t INDEX_CART = 6'd0;
  localparam dl_index_t INDEX_SPC = 6'd1;

endpackage

// ==== cart_loader.sv ====
`timescale 1ns/1ns

module cart_loader (
  input  logic                    clk_sys,
  input  logic                    reset,
  input  snes_glue_pkg::loader_t  loader,
  input  logic [31:0]             rom_file_size,
  input  snes_glue_pkg::core_rom_t core_rom,
  input  logic                    core_run,
  input  logic                    rfsh,
  output snes_glue_pkg::rom_req_t rom_req,
  output logic                    cart_dl,
  output logic                    spc_dl,
  output logic                    spc_mode,
  output snes_glue_pkg::dl_addr_t dl_addr_adj
);
  import snes_glue_pkg::*;

  logic has_header;

  // slot decode
  assign cart_dl = loader.download && (loader.index == INDEX_CART);
  assign spc_dl  = loader.download && (loader.index == INDEX_SPC);

  // size of 1024*n + 512 means a copier header is present
  assign has_header = (rom_file_size[9:0] == 10'(HEADER_BYTES));

  assign dl_addr_adj = has_header ? loader.addr - dl_addr_t'(HEADER_BYTES) : loader.addr;

  // rom port mux
  always_comb begin
    if (cart_dl) begin
      // image write, always full words
      rom_req.addr = dl_addr_adj;
      rom_req.data = loader.dout;
      rom_req.rd   = 1'b0;
      rom_req.wr   = loader.wr;
      rom_req.word = 1'b1;
    end else begin
      rom_req.addr = {1'b0, core_rom.addr};
      rom_req.data = core_rom.d;
      // core held: refresh strobe keeps the memory busy
      rom_req.rd   = core_run ? ~core_rom.oe_n : rfsh;
      rom_req.wr   = ~core_rom.we_n;
      rom_req.word = core_rom.word;
    end
  end

  // sound program mode, follows the slot of the last loader write
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      spc_mode <= 1'b0;
    end else if (loader.wr) begin
      spc_mode <= spc_dl;
    end
  end

endmodule

// ==== cart_info.sv ====
`timescale 1ns/1ns

module cart_info (
  input  logic                      clk_sys,
  input  logic                      reset,
  input  snes_glue_pkg::loader_t    loader,
  input  snes_glue_pkg::dl_addr_t   dl_addr_adj,
  input  logic                      cart_dl,
  output snes_glue_pkg::mask_t      rom_mask,
  output snes_glue_pkg::mask_t      ram_mask,
  output snes_glue_pkg::size_code_t sram_size,
  output snes_glue_pkg::rom_type_t  rom_type,
  output logic                      settle_busy
);
  import snes_glue_pkg::*;

  size_code_t  rom_code;
  size_code_t  ram_code;
  logic        cart_dl_q;
  settle_cnt_t settle_cnt;

  // first word of the image holds sizes and type
  always_ff @(posedge clk_sys) begin
    if (cart_dl && loader.wr && (dl_addr_adj == '0)) begin
      if (loader.dout[7:0] != 8'h00) begin
        // low nibble rom, high nibble ram
        {ram_code, rom_code} <= loader.dout[7:0];
      end else begin
        // empty size byte, assume large rom and no ram
        rom_code <= DEFAULT_ROM_SIZE;
        ram_code <= '0;
      end
      rom_type <= loader.dout[15:8];
    end
  end

  // settle countdown after the download ends
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      cart_dl_q  <= 1'b0;
      settle_cnt <= SETTLE_IDLE;
    end else begin
      cart_dl_q <= cart_dl;
      if (cart_dl_q && !cart_dl) begin
        settle_cnt <= SETTLE_COUNT;
      end else if ((settle_cnt != SETTLE_IDLE) && (settle_cnt != '0)) begin
        settle_cnt <= settle_cnt - 1'b1;
      end
    end
  end

  // also covers the idle value, core stays held until a cart arrives
  assign settle_busy = (settle_cnt != '0);

  // masks built on the last count, before the core is released
  always_ff @(posedge clk_sys) begin
    if (settle_cnt == settle_cnt_t'(1)) begin
      rom_mask <= (mask_t'(1024) << rom_code) - mask_t'(1);
      if (ram_code != '0) begin
        ram_mask <= (mask_t'(1024) << ram_code) - mask_t'(1);
      end else begin
        ram_mask <= '0;
      end
      sram_size <= ram_code;
    end
  end

endmodule

// ==== ram_clear.sv ====
`timescale 1ns/1ns

module ram_clear #(
  parameter int BSRAM_BITS     = 17,
  parameter int CLEAR_DIV_BITS = 2
) (
  input  logic                  clk_sys,
  input  logic                  reset,
  input  logic                  cart_dl,
  output logic                  clear_active,
  output logic [BSRAM_BITS-1:0] fill_addr
);

  logic                      cart_dl_q;
  // slows the fill for the save memory
  logic [CLEAR_DIV_BITS-1:0] clear_div;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      cart_dl_q    <= 1'b0;
      clear_active <= 1'b0;
      clear_div    <= '0;
      fill_addr    <= '0;
    end else begin
      cart_dl_q <= cart_dl;
      clear_div <= clear_div + 1'b1;

      // start on a new cart download
      if (!cart_dl_q && cart_dl) begin
        clear_active <= 1'b1;
      end
      // last address reached, stop
      if (&fill_addr) begin
        clear_active <= 1'b0;
      end

      if (clear_active) begin
        // one step per divider wrap
        if (clear_div == '0) begin
          fill_addr <= fill_addr + 1'b1;
        end
      end else begin
        fill_addr <= '0;
      end
    end
  end

endmodule

// ==== reset_gen.sv ====
`timescale 1ns/1ns

module reset_gen (
  input  logic clk_sys,
  input  logic reset,
  input  logic cart_dl,
  input  logic spc_dl,
  input  logic clear_active,
  input  logic settle_busy,
  output logic core_run,
  output logic rfsh
);

  logic [1:0] phase;
  logic       hold;

  // anything still loading or clearing keeps the core stopped
  assign hold = cart_dl || spc_dl || clear_active || settle_busy;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      // reset itself is the first hold source
      phase    <= '0;
      rfsh     <= 1'b0;
      core_run <= 1'b0;
    end else begin
      phase <= phase + 1'b1;
      // one refresh per four cycles
      rfsh  <= (phase == 2'd0);
      // run level changes on a fixed phase only
      if (phase == 2'd2) begin
        core_run <= !hold;
      end
    end
  end

endmodule

// ==== save_ram_port.sv ====
`timescale 1ns/1ns

module save_ram_port #(
  parameter int BSRAM_BITS = 17
) (
  input  logic                        save_download,
  input  logic                        sd_rd,
  input  logic                        sd_wr,
  input  logic [BSRAM_BITS-1:0]       sd_addr,
  input  snes_glue_pkg::byte_t        sd_dout,
  input  logic                        clear_active,
  input  logic [BSRAM_BITS-1:0]       fill_addr,
  input  snes_glue_pkg::core_bsram_t  core_bsram,
  input  snes_glue_pkg::word_t        bsram_rdata,
  output snes_glue_pkg::bsram_req_t   bsram_req,
  output snes_glue_pkg::byte_t        bsram_q
);
  import snes_glue_pkg::*;

  logic [BSRAM_BITS-1:0] sel_addr;
  byte_t                 sel_data;
  logic                  sel_wr;
  logic                  sel_rd;
  logic                  hi_lane;

  // save transfer first, then clear, then the core
  always_comb begin
    if (save_download) begin
      sel_addr = sd_addr;
      sel_data = sd_dout;
      sel_wr   = sd_wr;
      sel_rd   = sd_rd;
    end else if (clear_active) begin
      // fill with 0xff, write only
      sel_addr = fill_addr;
      sel_data = 8'hFF;
      sel_wr   = 1'b1;
      sel_rd   = 1'b0;
    end else begin
      sel_addr = core_bsram.addr[BSRAM_BITS-1:0];
      sel_data = core_bsram.d;
      sel_wr   = !core_bsram.ce_n && !core_bsram.we_n;
      sel_rd   = !core_bsram.ce_n && !core_bsram.oe_n;
    end
  end

  // odd byte address lands in the upper lane
  assign hi_lane = sel_addr[0];

  always_comb begin
    bsram_req.waddr = 16'(sel_addr >> 1);
    bsram_req.data  = hi_lane ? {sel_data, 8'h00} : {8'h00, sel_data};
    bsram_req.wr    = sel_wr;
    bsram_req.rd    = sel_rd;
    bsram_req.be_hi = hi_lane;
    bsram_req.be_lo = !hi_lane;
  end

  // read back from the same lane
  assign bsram_q = hi_lane ? bsram_rdata[15:8] : bsram_rdata[7:0];

endmodule

// ==== snes_glue_top.sv ====
`timescale 1ns/1ns

module snes_glue_top #(
  parameter int BSRAM_BITS     = 17,
  parameter int CLEAR_DIV_BITS = 2
) (
  input  logic                        clk_sys,
  input  logic                        reset,
  // loader
  input  snes_glue_pkg::loader_t      loader,
  input  logic [31:0]                 rom_file_size,
  input  logic                        save_download,
  input  logic                        sd_rd,
  input  logic                        sd_wr,
  input  logic [BSRAM_BITS-1:0]       sd_addr,
  input  snes_glue_pkg::byte_t        sd_dout,
  output snes_glue_pkg::byte_t        sd_buff_din,
  // core side
  input  snes_glue_pkg::core_rom_t    core_rom,
  input  snes_glue_pkg::core_bsram_t  core_bsram,
  output logic                        core_run,
  output snes_glue_pkg::byte_t        bsram_q,
  output snes_glue_pkg::mask_t        rom_mask,
  output snes_glue_pkg::mask_t        ram_mask,
  output snes_glue_pkg::rom_type_t    rom_type,
  output snes_glue_pkg::size_code_t   sram_size,
  output logic                        spc_mode,
  // memories
  output snes_glue_pkg::rom_req_t     rom_req,
  output snes_glue_pkg::bsram_req_t   bsram_req,
  input  snes_glue_pkg::word_t        bsram_rdata
);
  import snes_glue_pkg::*;

  logic                  cart_dl;
  logic                  spc_dl;
  dl_addr_t              dl_addr_adj;
  logic                  settle_busy;
  logic                  clear_active;
  logic [BSRAM_BITS-1:0] fill_addr;
  logic                  rfsh;

  cart_loader u_cart_loader (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .loader        (loader),
    .rom_file_size (rom_file_size),
    .core_rom      (core_rom),
    .core_run      (core_run),
    .rfsh          (rfsh),
    .rom_req       (rom_req),
    .cart_dl       (cart_dl),
    .spc_dl        (spc_dl),
    .spc_mode      (spc_mode),
    .dl_addr_adj   (dl_addr_adj)
  );

  cart_info u_cart_info (
    .clk_sys     (clk_sys),
    .reset       (reset),
    .loader      (loader),
    .dl_addr_adj (dl_addr_adj),
    .cart_dl     (cart_dl),
    .rom_mask    (rom_mask),
    .ram_mask    (ram_mask),
    .sram_size   (sram_size),
    .rom_type    (rom_type),
    .settle_busy (settle_busy)
  );

  ram_clear #(
    .BSRAM_BITS     (BSRAM_BITS),
    .CLEAR_DIV_BITS (CLEAR_DIV_BITS)
  ) u_ram_clear (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .cart_dl      (cart_dl),
    .clear_active (clear_active),
    .fill_addr    (fill_addr)
  );

  reset_gen u_reset_gen (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .cart_dl      (cart_dl),
    .spc_dl       (spc_dl),
    .clear_active (clear_active),
    .settle_busy  (settle_busy),
    .core_run     (core_run),
    .rfsh         (rfsh)
  );

  save_ram_port #(
    .BSRAM_BITS (BSRAM_BITS)
  ) u_save_ram_port (
    .save_download (save_download),
    .sd_rd         (sd_rd),
    .sd_wr         (sd_wr),
    .sd_addr       (sd_addr),
    .sd_dout       (sd_dout),
    .clear_active  (clear_active),
    .fill_addr     (fill_addr),
    .core_bsram    (core_bsram),
    .bsram_rdata   (bsram_rdata),
    .bsram_req     (bsram_req),
    .bsram_q       (bsram_q)
  );

  // save upload reads the same byte the core sees
  assign sd_buff_din = bsram_q;

endmodule

// ==== snes_glue_properties.sv ====
`timescale 1ns/1ns

module snes_glue_properties (
  input logic                      clk_sys,
  input logic                      reset,
  input logic                      cart_dl,
  input logic                      clear_active,
  input logic                      save_download,
  input logic                      rfsh,
  input logic                      core_run,
  input snes_glue_pkg::bsram_req_t bsram_req
);

  // clear owns the save ram unless a save transfer takes over
  a_no_read_in_clear: assert property (@(posedge clk_sys) disable iff (!reset)
    clear_active && !save_download |-> !bsram_req.rd)
    else $error("save ram read while the clear is running");

  // refresh is a single cycle pulse
  a_rfsh_single: assert property (@(posedge clk_sys) disable iff (!reset)
    rfsh |=> !rfsh)
    else $error("refresh strobe high on two cycles in a row");

  // run level follows the hold only on phase 2, so allow four cycles
  a_held_in_download: assert property (@(posedge clk_sys) disable iff (!reset)
    cart_dl && $past(cart_dl, 1) && $past(cart_dl, 2) && $past(cart_dl, 3)
    && $past(cart_dl, 4) |-> !core_run)
    else $error("core running during a cartridge download");

  a_wr_rd_exclusive: assert property (@(posedge clk_sys) disable iff (!reset)
    !(bsram_req.wr && bsram_req.rd))
    else $error("save ram write and read strobes at once");

endmodule

// ==== tb_snes_glue.sv ====
`timescale 1ns/1ns

module tb_snes_glue;
  import snes_glue_pkg::*;

  localparam int BSRAM_BITS     = 17;
  localparam int CLEAR_DIV_BITS = 2;
  localparam int CLK_PERIOD     = 40;
  // directed tests, one full clear, then some slack
  localparam int TEST_CYCLES    = 2000;
  localparam int CLEAR_CYCLES   = (1 << BSRAM_BITS) * 4;
  localparam int LIMIT_CYCLES   = TEST_CYCLES + CLEAR_CYCLES + 1000;

  logic                  clk_sys;
  logic                  reset;
  loader_t               loader;
  logic [31:0]           rom_file_size;
  logic                  save_download;
  logic                  sd_rd;
  logic                  sd_wr;
  logic [BSRAM_BITS-1:0] sd_addr;
  byte_t                 sd_dout;
  byte_t                 sd_buff_din;
  core_rom_t             core_rom;
  core_bsram_t           core_bsram;
  logic                  core_run;
  byte_t                 bsram_q;
  mask_t                 rom_mask;
  mask_t                 ram_mask;
  rom_type_t             rom_type;
  size_code_t            sram_size;
  logic                  spc_mode;
  rom_req_t              rom_req;
  bsram_req_t            bsram_req;
  word_t                 bsram_rdata;
  // save ram model, one word per lane pair
  word_t                 save_mem [0:(1 << (BSRAM_BITS-1))-1];
  int                    check_count;
  int                    error_count;

  snes_glue_top #(
    .BSRAM_BITS     (BSRAM_BITS),
    .CLEAR_DIV_BITS (CLEAR_DIV_BITS)
  ) u_dut (.*);

  bind snes_glue_top snes_glue_properties u_props (.*);

  initial begin
    clk_sys = 1'b0;
    forever #(CLK_PERIOD/2) clk_sys = ~clk_sys;
  end

  // reads are combinational
  assign bsram_rdata = save_mem[bsram_req.waddr];

  always @(posedge clk_sys) begin
    if (!reset) begin
      // pattern over the whole word address
      for (int i = 0; i < (1 << (BSRAM_BITS-1)); i++) begin
        save_mem[16'(i)] <= word_t'(i) ^ 16'h6C93;
      end
    end else if (bsram_req.wr) begin
      if (bsram_req.be_hi) begin
        save_mem[bsram_req.waddr][15:8] <= bsram_req.data[15:8];
      end
      if (bsram_req.be_lo) begin
        save_mem[bsram_req.waddr][7:0] <= bsram_req.data[7:0];
      end
    end
  end

  initial begin
    #(CLK_PERIOD * LIMIT_CYCLES);
    $display("timeout: the tests did not finish in %0d cycles", LIMIT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input mask_t got, input mask_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input dl_addr_t got, input dl_addr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // inputs change 5 ns after the rising edge
  task automatic step();
    @(posedge clk_sys);
    #5;
  endtask

  task automatic wait_settle();
    int n;
    n = 0;
    while (u_dut.settle_busy && n < 32) begin
      step();
      n++;
    end
    if (u_dut.settle_busy) begin
      error_count++;
      $display("settle countdown still busy after 32 cycles");
    end
  endtask

  // one word per write, a free cycle between writes
  task automatic load_image(input logic [31:0] size, input dl_addr_t base,
                            input word_t head, input int words);
    dl_addr_t exp_addr;
    rom_file_size   = size;
    loader.index    = INDEX_CART;
    loader.download = 1'b1;
    for (int i = 0; i < words; i++) begin
      step();
      loader.wr   = 1'b1;
      loader.addr = base + dl_addr_t'(2 * i);
      loader.dout = (i == 0) ? head : word_t'($urandom);
      // 512 left over a whole kilobyte means a copier header
      exp_addr = (size % 1024 == 512) ? loader.addr - 25'd512 : loader.addr;
      #10;
      check_addr("rom_req.addr", rom_req.addr, exp_addr);
      check_word("rom_req.data", rom_req.data, loader.dout);
      check_bit("rom_req.wr", rom_req.wr, 1'b1);
      check_bit("rom_req.rd", rom_req.rd, 1'b0);
      check_bit("rom_req.word", rom_req.word, 1'b1);
      step();
      loader.wr = 1'b0;
    end
    step();
    loader.download = 1'b0;
    step();
  endtask

  task automatic idle_after_reset();
    int pulses;
    int last;
    pulses = 0;
    last   = -1;
    check_bit("core_run", core_run, 1'b0);
    check_bit("spc_mode", spc_mode, 1'b0);
    check_bit("clear_active", u_dut.clear_active, 1'b0);
    check_bit("settle_busy", u_dut.settle_busy, 1'b1);
    core_rom.addr = 24'h12_3456;
    core_rom.d    = word_t'($urandom);
    #10;
    check_addr("rom_req.addr", rom_req.addr, {1'b0, core_rom.addr});
    check_word("rom_req.data", rom_req.data, core_rom.d);
    // held core, the port only sees refresh reads
    for (int i = 0; i < 16; i++) begin
      if (rom_req.rd) begin
        if (last >= 0 && i - last != 4) begin
          error_count++;
          $display("refresh pulses %0d cycles apart instead of 4", i - last);
        end
        pulses++;
        last = i;
      end
      step();
    end
    if (pulses != 4) begin
      error_count++;
      $display("%0d refresh pulses in 16 cycles instead of 4", pulses);
    end
  endtask

  task automatic cart_download_header();
    load_image(32'(1024 * 4 + 512), 25'd512, 16'h213A, 8);
    // sound program slot
    loader.index    = INDEX_SPC;
    loader.download = 1'b1;
    step();
    loader.wr   = 1'b1;
    loader.addr = '0;
    loader.dout = word_t'($urandom);
    step();
    loader.wr = 1'b0;
    check_bit("spc_mode", spc_mode, 1'b1);
    loader.download = 1'b0;
    loader.index    = INDEX_CART;
    step();
  endtask

  task automatic cart_info_capture();
    wait_settle();
    // rom code 0xa, ram code 3
    check_mask("rom_mask", rom_mask, 24'h0F_FFFF);
    check_mask("ram_mask", ram_mask, 24'h00_1FFF);
    check_byte("sram_size", byte_t'(sram_size), 8'h03);
    check_byte("rom_type", rom_type, 8'h21);
    // empty size byte, no copier header this time
    load_image(32'(1024 * 8), 25'd0, 16'h3500, 4);
    check_bit("spc_mode", spc_mode, 1'b0);
    wait_settle();
    check_mask("rom_mask", rom_mask, 24'h3F_FFFF);
    check_mask("ram_mask", ram_mask, 24'h00_0000);
    check_byte("sram_size", byte_t'(sram_size), 8'h00);
    check_byte("rom_type", rom_type, 8'h35);
  endtask

  task automatic save_ram_clear();
    logic [BSRAM_BITS-1:0] seen;
    logic [BSRAM_BITS-1:0] expect_addr;
    int                    run;
    int                    steps;
    int                    n;
    run   = 0;
    steps = 0;
    n     = 0;
    expect_addr = '0;
    #10;
    check_bit("clear_active", u_dut.clear_active, 1'b1);
    while (u_dut.clear_active && n < CLEAR_CYCLES + 16) begin
      // byte address rebuilt from word address and lane
      seen = {bsram_req.waddr[BSRAM_BITS-2:0], bsram_req.be_hi};
      check_bit("bsram_req.wr", bsram_req.wr, 1'b1);
      check_bit("bsram_req.be_lo", bsram_req.be_lo, ~bsram_req.be_hi);
      check_byte("bsram_req.data",
                 bsram_req.be_hi ? bsram_req.data[15:8] : bsram_req.data[7:0], 8'hFF);
      if (n == 0) begin
        expect_addr = seen;
        run = 1;
      end else if (seen == expect_addr) begin
        run++;
      end else if (seen == expect_addr + 1'b1) begin
        // first run may be partial
        if (steps > 0 && run != (1 << CLEAR_DIV_BITS)) begin
          error_count++;
          $display("fill address held %0d cycles at %h", run, expect_addr);
        end
        steps++;
        expect_addr = seen;
        run = 1;
      end else begin
        error_count++;
        $display("fill address jumped from %h to %h", expect_addr, seen);
        expect_addr = seen;
      end
      n++;
      @(posedge clk_sys);
      #15;
    end
    if (expect_addr != '1) begin
      error_count++;
      $display("clear stopped at byte address %h before the end of the save ram", expect_addr);
    end
    for (int i = 0; i < (1 << (BSRAM_BITS-1)); i++) begin
      if (save_mem[16'(i)] !== 16'hFFFF) begin
        check_word($sformatf("save_mem[%0d]", i), save_mem[16'(i)], 16'hFFFF);
        break;
      end
    end
    // run level needs up to four cycles
    n = 0;
    while (!core_run && n < 5) begin
      step();
      n++;
    end
    check_bit("core_run", core_run, 1'b1);
    check_bit("settle_busy", u_dut.settle_busy, 1'b0);
  endtask

  task automatic save_transfer();
    byte_t odd_byte;
    byte_t even_byte;
    odd_byte  = byte_t'($urandom);
    even_byte = byte_t'($urandom);
    save_download = 1'b1;
    sd_wr   = 1'b1;
    sd_addr = 17'h0_0123;
    sd_dout = odd_byte;
    #10;
    check_bit("bsram_req.be_hi", bsram_req.be_hi, 1'b1);
    check_bit("bsram_req.be_lo", bsram_req.be_lo, 1'b0);
    check_word("bsram_req.waddr", bsram_req.waddr, 16'h0091);
    check_byte("bsram_req.data", bsram_req.data[15:8], odd_byte);
    step();
    sd_addr = 17'h0_0456;
    sd_dout = even_byte;
    #10;
    check_bit("bsram_req.be_hi", bsram_req.be_hi, 1'b0);
    check_bit("bsram_req.be_lo", bsram_req.be_lo, 1'b1);
    check_word("bsram_req.waddr", bsram_req.waddr, 16'h022B);
    check_byte("bsram_req.data", bsram_req.data[7:0], even_byte);
    step();
    sd_wr = 1'b0;
    // other lane keeps the clear value
    check_word("save_mem[0x091]", save_mem[16'h0091], {odd_byte, 8'hFF});
    check_word("save_mem[0x22b]", save_mem[16'h022B], {8'hFF, even_byte});
    sd_rd   = 1'b1;
    sd_addr = 17'h0_0123;
    #10;
    check_byte("bsram_q", bsram_q, odd_byte);
    check_byte("sd_buff_din", sd_buff_din, odd_byte);
    step();
    sd_addr = 17'h0_0456;
    #10;
    check_byte("bsram_q", bsram_q, even_byte);
    step();
    sd_rd = 1'b0;
    save_download = 1'b0;
    // same bytes seen from the core side
    core_bsram.ce_n = 1'b0;
    core_bsram.oe_n = 1'b0;
    core_bsram.addr = 20'h0_0123;
    #10;
    check_bit("bsram_req.rd", bsram_req.rd, 1'b1);
    check_byte("bsram_q", bsram_q, odd_byte);
    step();
    core_bsram.addr = 20'h0_0456;
    #10;
    check_byte("bsram_q", bsram_q, even_byte);
    step();
    core_bsram.ce_n = 1'b1;
    core_bsram.oe_n = 1'b1;
  endtask

  initial begin
    // fixed seed for the data words
    void'($urandom(32'h4d21));
    check_count   = 0;
    error_count   = 0;
    reset         = 1'b0;
    loader        = '0;
    rom_file_size = '0;
    save_download = 1'b0;
    sd_rd         = 1'b0;
    sd_wr         = 1'b0;
    sd_addr       = '0;
    sd_dout       = '0;
    core_rom      = '0;
    core_rom.oe_n = 1'b1;
    core_rom.we_n = 1'b1;
    core_bsram    = '0;
    core_bsram.ce_n = 1'b1;
    core_bsram.oe_n = 1'b1;
    core_bsram.we_n = 1'b1;
    repeat (16) step();
    reset = 1'b1;
    repeat (2) step();
    idle_after_reset();
    cart_download_header();
    cart_info_capture();
    save_ram_clear();
    save_transfer();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
snes_glue_pkg.sv
cart_loader.sv
cart_info.sv
ram_clear.sv
reset_gen.sv
save_ram_port.sv
snes_glue_top.sv
snes_glue_properties.sv
tb_snes_glue.sv

// ==== Makefile ====
TOP := tb_snes_glue

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" sim.log; then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
